// ==== lsq_pkg.sv ====
// shared types and sizes for the load/store buffer
// tag 0 always means the operand value is present
// funct codes follow RV32I funct3 for loads
package lsq_pkg;

    // buffer depth and entry index width
    localparam int NUM_ENTRIES = 3;
    localparam int IDX_W       = $clog2(NUM_ENTRIES);

    // producer tags
    localparam int TAG_W = 3;

    // older uncommitted stores seen by a load
    localparam int STORE_CNT_W = 3;

    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic
    {
        op_load  = 1'b0,
        op_store = 1'b1
    } ls_op_e;

    typedef enum logic [2:0]
    {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct_e;

    // one memory word, seen as byte lanes or halfword lanes
    typedef union packed
    {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

// ==== lsb_dispatch_if.sv ====
// one load or store micro-op from dispatch into the buffer
// valid/ready handshake, accepted at an edge with both high
// offset arrives already sign-extended to 32 bits
`timescale 1ns/1ps

interface lsb_dispatch_if;
    logic                  valid;
    logic                  ready;
    lsq_pkg::ls_op_e       op;
    lsq_pkg::load_funct_e  funct;
    logic [31:0]           base_val;
    lsq_pkg::tag_t         base_tag;
    logic [31:0]           data_val;
    lsq_pkg::tag_t         data_tag;
    logic [31:0]           offset;
    lsq_pkg::tag_t         dest;

    modport src (
        output valid, op, funct, base_val, base_tag, data_val, data_tag, offset, dest,
        input  ready
    );

    modport sink (
        input  valid, op, funct, base_val, base_tag, data_val, data_tag, offset, dest,
        output ready
    );
endinterface

// ==== load_read_if.sv ====
// read requests from the buffer to the memory sequencer
// start is a one-cycle pulse, only given while busy is low
// done is a one-cycle pulse with rdata valid
`timescale 1ns/1ps

interface load_read_if;
    logic        start;
    logic [31:0] addr;
    logic        busy;
    logic        done;
    logic [31:0] rdata;

    // buffer side
    modport buffer (output start, output addr, input busy, input done, input rdata);

    modport port (input start, input addr, output busy, output done, output rdata);
endinterface

// ==== load_aligner.sv ====
// picks the addressed lane out of a read word and extends it
// accesses are assumed naturally aligned, so lh/lhu only use byte_off[1]
`timescale 1ns/1ps

module load_aligner (
    input  lsq_pkg::load_funct_e funct,
    input  logic [1:0]           byte_off,
    input  lsq_pkg::mem_word_u   word,
    output logic [31:0]          val
);
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign lane_b = word.bytes[byte_off];
    assign lane_h = word.halves[byte_off[1]];

    always_comb
    begin
        case (funct)
            lsq_pkg::lb:
            begin
                val = {{24{lane_b[7]}}, lane_b};
            end
            lsq_pkg::lbu:
            begin
                val = {24'b0, lane_b};
            end
            lsq_pkg::lh:
            begin
                val = {{16{lane_h[15]}}, lane_h};
            end
            lsq_pkg::lhu:
            begin
                val = {16'b0, lane_h};
            end
            default:
            begin
                // lw and anything undecoded
                val = word;
            end
        endcase
    end

endmodule

// ==== dmem_read_port.sv ====
// four-phase req/ack read sequencer for data memory
// one read at a time; mem_addr is word-aligned and held while mem_req is high
// a flush mid-read lets the handshake finish but suppresses done
`timescale 1ns/1ps

module dmem_read_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    load_read_if.port   rd,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata
);
    enum logic [1:0] {idle, req, wait_release} state;
    logic discard;

    assign mem_req = (state == req);
    assign rd.busy = (state != idle);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= idle;
            discard <= 1'b0;
            rd.done <= 1'b0;
        end
        else
        begin
            rd.done <= 1'b0;
            case (state)
                idle:
                begin
                    if (rd.start)
                    begin
                        state   <= req;
                        discard <= flush;
                    end
                end
                req:
                begin
                    if (flush)
                    begin
                        discard <= 1'b1;
                    end
                    if (mem_ack)
                    begin
                        state   <= wait_release;
                        rd.done <= !(discard || flush);
                    end
                end
                default:
                begin
                    // wait for the memory to drop ack
                    if (!mem_ack)
                    begin
                        state   <= idle;
                        discard <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && rd.start)
        begin
            mem_addr <= {rd.addr[31:2], 2'b00};
        end
        if (state == req && mem_ack)
        begin
            rd.rdata <= mem_rdata;
        end
    end

    a_req_after_release: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> $past(!mem_ack));

endmodule

// ==== lsb_rs.sv ====
// three-entry load/store reservation buffer
// a load waits until every older store has been committed, no forwarding
// one load in memory at a time; a load result wins the bus over a store
// misaligned accesses are not supported
`timescale 1ns/1ps

module lsb_rs (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    lsb_dispatch_if.sink  disp,
    load_read_if.buffer   rd,
    input  logic          cdb_valid,
    input  lsq_pkg::tag_t cdb_tag,
    input  logic [31:0]   cdb_val,
    input  logic          commit_store,
    output logic          res_valid,
    output logic          res_is_store,
    output lsq_pkg::tag_t res_tag,
    output logic [31:0]   res_val,
    output logic [31:0]   res_addr
);
    logic [lsq_pkg::NUM_ENTRIES-1:0] busy;
    logic [lsq_pkg::NUM_ENTRIES-1:0] issued;
    logic [lsq_pkg::IDX_W-1:0]       age      [lsq_pkg::NUM_ENTRIES];
    logic [31:0]                     base_val [lsq_pkg::NUM_ENTRIES];
    lsq_pkg::tag_t                   base_tag [lsq_pkg::NUM_ENTRIES];
    logic [31:0]                     data_val [lsq_pkg::NUM_ENTRIES];
    lsq_pkg::tag_t                   data_tag [lsq_pkg::NUM_ENTRIES];
    logic [31:0]                     offset   [lsq_pkg::NUM_ENTRIES];
    lsq_pkg::ls_op_e                 op       [lsq_pkg::NUM_ENTRIES];
    lsq_pkg::load_funct_e            funct    [lsq_pkg::NUM_ENTRIES];
    lsq_pkg::tag_t                   dest     [lsq_pkg::NUM_ENTRIES];
    logic [lsq_pkg::STORE_CNT_W-1:0] older    [lsq_pkg::NUM_ENTRIES];
    logic [lsq_pkg::STORE_CNT_W-1:0] store_count;

    logic [lsq_pkg::NUM_ENTRIES-1:0] load_ok;
    logic [lsq_pkg::NUM_ENTRIES-1:0] store_ok;
    logic [lsq_pkg::IDX_W-1:0]       alloc_idx;
    logic [lsq_pkg::IDX_W-1:0]       ld_sel;
    logic [lsq_pkg::IDX_W-1:0]       st_sel;
    logic [lsq_pkg::IDX_W-1:0]       load_idx;
    logic [lsq_pkg::IDX_W-1:0]       free_idx;
    logic                            accept;
    logic                            new_store;
    logic                            issue;
    logic                            free_valid;
    logic [31:0]                     load_word;

    // age counts the younger busy entries, so the largest age is oldest
    function automatic logic [lsq_pkg::IDX_W-1:0] pick_oldest(
        input logic [lsq_pkg::NUM_ENTRIES-1:0] mask
    );
        logic [lsq_pkg::IDX_W-1:0] sel;
        logic                      found;
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < lsq_pkg::NUM_ENTRIES; i++)
        begin
            if (mask[i] && (!found || age[i] > age[sel]))
            begin
                sel   = i[lsq_pkg::IDX_W-1:0];
                found = 1'b1;
            end
        end
        return sel;
    endfunction

    function automatic logic cdb_hit(input lsq_pkg::tag_t tag);
        return cdb_valid && tag != '0 && tag == cdb_tag;
    endfunction

    always_comb
    begin
        alloc_idx = '0;
        for (int i = lsq_pkg::NUM_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_idx = i[lsq_pkg::IDX_W-1:0];
            end
        end
        for (int i = 0; i < lsq_pkg::NUM_ENTRIES; i++)
        begin
            load_ok[i]  = busy[i] && op[i] == lsq_pkg::op_load && !issued[i]
                          && base_tag[i] == '0 && older[i] == '0;
            store_ok[i] = busy[i] && op[i] == lsq_pkg::op_store
                          && base_tag[i] == '0 && data_tag[i] == '0;
        end
        ld_sel = pick_oldest(load_ok);
        st_sel = pick_oldest(store_ok);
    end

    assign disp.ready = ~&busy;
    assign accept     = disp.valid && disp.ready;
    assign new_store  = accept && disp.op == lsq_pkg::op_store;
    assign issue      = |load_ok && !rd.busy && !rd.start;
    assign free_valid = rd.done || |store_ok;
    assign free_idx   = rd.done ? load_idx : st_sel;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            busy   <= '0;
            issued <= '0;
            for (int i = 0; i < lsq_pkg::NUM_ENTRIES; i++)
            begin
                age[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < lsq_pkg::NUM_ENTRIES; i++)
            begin
                if (accept && alloc_idx == i)
                begin
                    busy[i]     <= 1'b1;
                    issued[i]   <= 1'b0;
                    age[i]      <= '0;
                    op[i]       <= disp.op;
                    funct[i]    <= disp.funct;
                    offset[i]   <= disp.offset;
                    dest[i]     <= disp.dest;
                    older[i]    <= store_count - commit_store;
                    base_tag[i] <= cdb_hit(disp.base_tag) ? '0 : disp.base_tag;
                    base_val[i] <= cdb_hit(disp.base_tag) ? cdb_val : disp.base_val;
                    data_tag[i] <= cdb_hit(disp.data_tag) ? '0 : disp.data_tag;
                    data_val[i] <= cdb_hit(disp.data_tag) ? cdb_val : disp.data_val;
                end
                else if (busy[i])
                begin
                    if (free_valid && free_idx == i)
                    begin
                        busy[i] <= 1'b0;
                    end
                    if (issue && ld_sel == i)
                    begin
                        issued[i] <= 1'b1;
                    end
                    age[i] <= age[i] + accept - (free_valid && age[free_idx] < age[i]);
                    if (cdb_hit(base_tag[i]))
                    begin
                        base_tag[i] <= '0;
                        base_val[i] <= cdb_val;
                    end
                    if (cdb_hit(data_tag[i]))
                    begin
                        data_tag[i] <= '0;
                        data_val[i] <= cdb_val;
                    end
                    if (commit_store && older[i] != '0)
                    begin
                        older[i] <= older[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            store_count <= '0;
        end
        else if (new_store && !commit_store)
        begin
            store_count <= store_count + 1'b1;
        end
        else if (commit_store && !new_store)
        begin
            store_count <= store_count - 1'b1;
        end
    end

    // start goes out one edge after the load becomes eligible
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rd.start <= 1'b0;
        end
        else
        begin
            rd.start <= issue;
        end
        if (issue)
        begin
            rd.addr  <= base_val[ld_sel] + offset[ld_sel];
            load_idx <= ld_sel;
        end
    end

    load_aligner u_align (
        .funct    (funct[load_idx]),
        .byte_off (rd.addr[1:0]),
        .word     (rd.rdata),
        .val      (load_word)
    );

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= free_valid;
        end
        if (rd.done)
        begin
            res_is_store <= 1'b0;
            res_tag      <= dest[load_idx];
            res_val      <= load_word;
            res_addr     <= rd.addr;
        end
        else
        begin
            res_is_store <= 1'b1;
            res_tag      <= dest[st_sel];
            res_val      <= data_val[st_sel];
            res_addr     <= base_val[st_sel] + offset[st_sel];
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        rd.start |-> !rd.busy);

    a_store_count_floor: assert property (@(posedge clk) disable iff (rst || flush)
        commit_store |-> store_count != '0);

endmodule

// ==== lsq_top.sv ====
// load/store part of the core, plain ports on the outside
// the environment commits stores itself and pulses commit_store for each one
// memory side is a four-phase req/ack read port
`timescale 1ns/1ps

module lsq_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 disp_valid,
    input  lsq_pkg::ls_op_e      disp_op,
    input  lsq_pkg::load_funct_e disp_funct,
    input  logic [31:0]          disp_base_val,
    input  lsq_pkg::tag_t        disp_base_tag,
    input  logic [31:0]          disp_data_val,
    input  lsq_pkg::tag_t        disp_data_tag,
    input  logic [31:0]          disp_offset,
    input  lsq_pkg::tag_t        disp_dest,
    output logic                 disp_ready,
    input  logic                 cdb_valid,
    input  lsq_pkg::tag_t        cdb_tag,
    input  logic [31:0]          cdb_val,
    input  logic                 commit_store,
    output logic                 mem_req,
    output logic [31:0]          mem_addr,
    input  logic                 mem_ack,
    input  logic [31:0]          mem_rdata,
    output logic                 res_valid,
    output logic                 res_is_store,
    output lsq_pkg::tag_t        res_tag,
    output logic [31:0]          res_val,
    output logic [31:0]          res_addr
);
    lsb_dispatch_if disp_bus ();
    load_read_if    read_bus ();

    assign disp_bus.valid    = disp_valid;
    assign disp_bus.op       = disp_op;
    assign disp_bus.funct    = disp_funct;
    assign disp_bus.base_val = disp_base_val;
    assign disp_bus.base_tag = disp_base_tag;
    assign disp_bus.data_val = disp_data_val;
    assign disp_bus.data_tag = disp_data_tag;
    assign disp_bus.offset   = disp_offset;
    assign disp_bus.dest     = disp_dest;
    assign disp_ready        = disp_bus.ready;

    lsb_rs u_rs (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .disp         (disp_bus.sink),
        .rd           (read_bus.buffer),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_val      (cdb_val),
        .commit_store (commit_store),
        .res_valid    (res_valid),
        .res_is_store (res_is_store),
        .res_tag      (res_tag),
        .res_val      (res_val),
        .res_addr     (res_addr)
    );

    dmem_read_port u_rdport (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .rd        (read_bus.port),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== lsq_tb.sv ====
// directed testbench for lsq_top
// inputs change 1 ns after the rising edge, outputs are sampled at the same point
// memory model answers reads from 16 random words after 1 to 3 cycles
// stops at the first mismatch
`timescale 1ns/1ps

module lsq_tb;
    // roughly 40 loads and stores at under 20 cycles each, with margin
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int RESULT_WAIT     = 40;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 disp_valid;
    lsq_pkg::ls_op_e      disp_op;
    lsq_pkg::load_funct_e disp_funct;
    logic [31:0]          disp_base_val;
    lsq_pkg::tag_t        disp_base_tag;
    logic [31:0]          disp_data_val;
    lsq_pkg::tag_t        disp_data_tag;
    logic [31:0]          disp_offset;
    lsq_pkg::tag_t        disp_dest;
    logic                 disp_ready;
    logic                 cdb_valid;
    lsq_pkg::tag_t        cdb_tag;
    logic [31:0]          cdb_val;
    logic                 commit_store;
    logic                 mem_req;
    logic [31:0]          mem_addr;
    logic                 mem_ack;
    logic [31:0]          mem_rdata;
    logic                 res_valid;
    logic                 res_is_store;
    lsq_pkg::tag_t        res_tag;
    logic [31:0]          res_val;
    logic [31:0]          res_addr;

    integer               seed;
    lsq_pkg::mem_word_u   mem_words [16];

    lsq_top dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run;
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input lsq_pkg::tag_t exp, input lsq_pkg::tag_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected tag %0d, got %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %b, got %b", name, exp, act);
            abort_run();
        end
    endtask

    // RV32I load rule: shift the addressed lane down, then extend
    function automatic logic [31:0] extend_load(input lsq_pkg::load_funct_e funct,
                                                input logic [1:0] off, input logic [31:0] word);
        logic [31:0] lane;
        lane = word >> (8 * off);
        case (funct)
            lsq_pkg::lb:  extend_load = {{24{lane[7]}}, lane[7:0]};
            lsq_pkg::lbu: extend_load = {24'b0, lane[7:0]};
            lsq_pkg::lh:  extend_load = {{16{lane[15]}}, lane[15:0]};
            lsq_pkg::lhu: extend_load = {16'b0, lane[15:0]};
            default:      extend_load = word;
        endcase
    endfunction

    function automatic int access_size(input lsq_pkg::load_funct_e funct);
        case (funct)
            lsq_pkg::lb, lsq_pkg::lbu: access_size = 1;
            lsq_pkg::lh, lsq_pkg::lhu: access_size = 2;
            default:                   access_size = 4;
        endcase
    endfunction

    task automatic dispatch(input lsq_pkg::ls_op_e op, input lsq_pkg::load_funct_e funct,
                            input logic [31:0] base_val, input lsq_pkg::tag_t base_tag,
                            input logic [31:0] data_val, input lsq_pkg::tag_t data_tag,
                            input logic [31:0] offset, input lsq_pkg::tag_t dest);
        int waited;
        waited        = 0;
        disp_valid    = 1'b1;
        disp_op       = op;
        disp_funct    = funct;
        disp_base_val = base_val;
        disp_base_tag = base_tag;
        disp_data_val = data_val;
        disp_data_tag = data_tag;
        disp_offset   = offset;
        disp_dest     = dest;
        while (!disp_ready)
        begin
            step();
            waited++;
            if (waited > RESULT_WAIT)
            begin
                stop_with_error("dispatch stalled: disp_ready never came back high");
            end
        end
        // accepted at this edge
        step();
        disp_valid = 1'b0;
    endtask

    task automatic broadcast(input lsq_pkg::tag_t tag, input logic [31:0] val);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_val   = val;
        step();
        cdb_valid = 1'b0;
    endtask

    task automatic commit_one_store;
        commit_store = 1'b1;
        step();
        commit_store = 1'b0;
    endtask

    task automatic expect_result(input string name, input logic is_store, input lsq_pkg::tag_t tag,
                                 input logic [31:0] val, input logic [31:0] addr);
        int waited;
        waited = 0;
        while (!res_valid)
        begin
            step();
            waited++;
            if (waited > RESULT_WAIT)
            begin
                stop_with_error($sformatf("%s: no result after %0d cycles", name, RESULT_WAIT));
            end
        end
        check_bit({name, " is_store"}, is_store, res_is_store);
        check_tag({name, " tag"}, tag, res_tag);
        check_word({name, " value"}, val, res_val);
        check_word({name, " address"}, addr, res_addr);
        step();
    endtask

    task automatic expect_no_result(input string name, input int cycles, input logic no_req);
        repeat (cycles)
        begin
            check_bit({name, " res_valid"}, 1'b0, res_valid);
            if (no_req)
            begin
                check_bit({name, " mem_req"}, 1'b0, mem_req);
            end
            step();
        end
    endtask

    task automatic wait_for_mem_req;
        int waited;
        waited = 0;
        while (!mem_req)
        begin
            step();
            waited++;
            if (waited > RESULT_WAIT)
            begin
                stop_with_error("mem_req never rose for a ready load");
            end
        end
    endtask

    task automatic serve_read;
        logic [31:0] addr;
        int          delay;
        addr  = mem_addr;
        delay = 1 + $unsigned($random(seed)) % 3;
        if (addr[1:0] != 2'b00)
        begin
            stop_with_error("memory model: mem_addr is not word aligned");
        end
        // the model holds 16 words starting at 0x1000
        if (addr[31:6] != 26'h40)
        begin
            stop_with_error("memory model: mem_addr is outside the modeled words");
        end
        repeat (delay - 1)
        begin
            step();
            if (!mem_req || mem_addr !== addr)
            begin
                stop_with_error("memory model: mem_req dropped or mem_addr moved before mem_ack");
            end
        end
        mem_rdata = mem_words[addr[5:2]];
        mem_ack   = 1'b1;
        while (mem_req)
        begin
            step();
        end
        mem_ack = 1'b0;
    endtask

    initial
    begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            step();
            if (mem_req && !rst)
            begin
                serve_read();
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error("watchdog expired before the tests finished");
    end

    task automatic reset_values;
        check_bit("reset disp_ready", 1'b1, disp_ready);
        check_bit("reset mem_req", 1'b0, mem_req);
        check_bit("reset res_valid", 1'b0, res_valid);
    endtask

    task automatic store_result;
        dispatch(lsq_pkg::op_store, lsq_pkg::lw, 32'h1000, 0, 32'hdead_beef, 0, 32'h24, 5);
        check_bit("store not yet reported", 1'b0, res_valid);
        step();
        check_bit("store one edge after accept", 1'b1, res_valid);
        expect_result("store", 1'b1, 5, 32'hdead_beef, 32'h1024);
        commit_one_store();
    endtask

    task automatic load_extraction;
        lsq_pkg::load_funct_e kinds [5];
        int                   idx;
        int                   n;
        logic [31:0]          base;
        lsq_pkg::tag_t        tag;
        kinds = '{lsq_pkg::lb, lsq_pkg::lh, lsq_pkg::lw, lsq_pkg::lbu, lsq_pkg::lhu};
        n     = 0;
        for (int rep = 0; rep < 2; rep++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                for (int off = 0; off < 4; off += access_size(kinds[k]))
                begin
                    idx  = $unsigned($random(seed)) % 16;
                    base = 32'h1000 + idx * 4;
                    tag  = lsq_pkg::tag_t'(1 + n % 7);
                    n++;
                    dispatch(lsq_pkg::op_load, kinds[k], base, 0, 0, 0, off, tag);
                    expect_result($sformatf("load %s offset %0d", kinds[k].name(), off), 1'b0, tag,
                                  extend_load(kinds[k], off[1:0], mem_words[idx]), base + off);
                end
            end
        end
    endtask

    task automatic operand_wakeup;
        dispatch(lsq_pkg::op_store, lsq_pkg::lw, 32'hbad0_0000, 3, 32'hbad0_0001, 4, 32'h8, 2);
        expect_no_result("store waiting on tags", 2, 1'b1);
        broadcast(3, 32'h1100);
        broadcast(4, 32'h55aa_1234);
        expect_result("woken store", 1'b1, 2, 32'h55aa_1234, 32'h1108);
        commit_one_store();
        dispatch(lsq_pkg::op_load, lsq_pkg::lw, 32'hbad0_0002, 6, 0, 0, 32'h4, 3);
        broadcast(6, 32'h1020);
        expect_result("woken load", 1'b0, 3,
                      extend_load(lsq_pkg::lw, 2'b00, mem_words[9]), 32'h1024);
    endtask

    task automatic store_ordering;
        dispatch(lsq_pkg::op_store, lsq_pkg::lw, 32'h1000, 0, 32'h1234_5678, 0, 32'h0, 4);
        dispatch(lsq_pkg::op_load, lsq_pkg::lbu, 32'h1000, 0, 0, 0, 32'h13, 5);
        expect_result("older store", 1'b1, 4, 32'h1234_5678, 32'h1000);
        expect_no_result("load behind uncommitted store", 5, 1'b1);
        commit_one_store();
        expect_result("load after commit", 1'b0, 5,
                      extend_load(lsq_pkg::lbu, 2'b11, mem_words[4]), 32'h1013);
    endtask

    task automatic full_and_flush;
        dispatch(lsq_pkg::op_store, lsq_pkg::lw, 32'h1000, 0, 32'h0, 0, 32'h0, 1);
        dispatch(lsq_pkg::op_load, lsq_pkg::lw, 32'h1000, 0, 0, 0, 32'h0, 2);
        dispatch(lsq_pkg::op_load, lsq_pkg::lh, 32'h1004, 0, 0, 0, 32'h2, 3);
        dispatch(lsq_pkg::op_load, lsq_pkg::lb, 32'h1008, 0, 0, 0, 32'h1, 4);
        check_bit("full buffer disp_ready", 1'b0, disp_ready);
        expect_no_result("full buffer held", 3, 1'b1);
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_bit("disp_ready after flush", 1'b1, disp_ready);
        expect_no_result("after flush", 5, 1'b1);
        // flush while the read handshake is open
        dispatch(lsq_pkg::op_load, lsq_pkg::lw, 32'h1010, 0, 0, 0, 32'h0, 6);
        wait_for_mem_req();
        flush = 1'b1;
        step();
        flush = 1'b0;
        expect_no_result("discarded read", 10, 1'b0);
        check_bit("handshake closed mem_req", 1'b0, mem_req);
        dispatch(lsq_pkg::op_load, lsq_pkg::lhu, 32'h1018, 0, 0, 0, 32'h2, 7);
        expect_result("load after flush", 1'b0, 7,
                      extend_load(lsq_pkg::lhu, 2'b10, mem_words[6]), 32'h101a);
    endtask

    initial
    begin
        seed          = 32'h9d88_f530;
        rst           = 1'b1;
        flush         = 1'b0;
        disp_valid    = 1'b0;
        disp_op       = lsq_pkg::op_load;
        disp_funct    = lsq_pkg::lw;
        disp_base_val = '0;
        disp_base_tag = '0;
        disp_data_val = '0;
        disp_data_tag = '0;
        disp_offset   = '0;
        disp_dest     = '0;
        cdb_valid     = 1'b0;
        cdb_tag       = '0;
        cdb_val       = '0;
        commit_store  = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            mem_words[i] = $random(seed);
        end
        repeat (4) step();
        rst = 1'b0;
        reset_values();
        store_result();
        load_extraction();
        operand_wakeup();
        store_ordering();
        full_and_flush();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== lsq_top.f ====
lsq_pkg.sv
lsb_dispatch_if.sv
load_read_if.sv
load_aligner.sv
dmem_read_port.sv
lsb_rs.sv
lsq_top.sv
lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compiles lsq_tb with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f lsq_top.f \
    --top-module lsq_tb -o lsq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/lsq_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation finished cleanly"
exit 0
